//--- common/uart_pkg.sv
// UART shared definitions
// Widths, register map, bus and line structs, FSM encodings and reset
// values for a 16550-style UART with a fixed 8N1 frame

package uart_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned DataWidth      = 32;  // Bus data
  localparam int unsigned AddrWidth      = 32;  // Bus address
  localparam int unsigned AddrOffset     = 2;   // Byte bits dropped from addr
  localparam int unsigned AddrBits       = 3;   // Eight word slots
  localparam int unsigned RegWidth       = 8;
  localparam int unsigned OversampleRate = 16;  // Ticks per bit
  localparam int unsigned TickCntWidth   = $clog2(OversampleRate);

  typedef logic [RegWidth-1:0]         byte_t;      // One character
  typedef logic [2*RegWidth-1:0]       divisor_t;   // {DLM, DLL}
  typedef logic [AddrBits-1:0]         reg_addr_t;  // Word address
  typedef logic [TickCntWidth-1:0]     tick_cnt_t;  // Ticks within a bit
  typedef logic [$clog2(RegWidth)-1:0] bit_cnt_t;   // Data bit index

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Shared slots, meaning depends on DLAB
  localparam reg_addr_t RHR_THR_DLL = 3'd0;
  localparam reg_addr_t IER_DLM     = 3'd1;
  localparam reg_addr_t LCR         = 3'd3;
  localparam reg_addr_t LSR         = 3'd5;  // DLAB 0 only
  localparam reg_addr_t SPR         = 3'd7;  // Scratch, reads zero

  localparam int unsigned LCR_DLAB = 7;  // Divisor latch access

  // LSR bit positions
  localparam int unsigned LSR_DR   = 0;
  localparam int unsigned LSR_OE   = 1;
  localparam int unsigned LSR_FE   = 3;
  localparam int unsigned LSR_THRE = 5;
  localparam int unsigned LSR_TEMT = 6;

  // Reset values
  localparam byte_t    REG_RESET_LCR = 8'h00;
  localparam divisor_t REG_RESET_DIV = 16'h0001;  // Fastest baud

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;  // One cycle after gnt
    logic [DataWidth-1:0] rdata;
    logic                 err;     // Unmapped slot
  } bus_rsp_t;

  // Regs to transmitter
  typedef struct packed {
    logic  start;  // Single cycle
    byte_t data;
  } tx_cmd_t;

  // Receiver to regs
  typedef struct packed {
    logic  valid;      // Single cycle
    byte_t data;
    logic  frame_err;  // Stop bit seen low
  } rx_event_t;

  ////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

//--- hw/uart_regs/uart_regs.sv
// UART register block
// Bus slave with request/grant and a read response one cycle later.
// Holds IER, LCR, divisor and LSR status, decodes with DLAB,
// and hands THR writes to the transmitter

module uart_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  uart_pkg::bus_req_t  bus_req_i,
  output uart_pkg::bus_rsp_t  bus_rsp_o,
  output uart_pkg::tx_cmd_t   tx_cmd_o,
  input  logic                tx_busy_i,
  input  uart_pkg::rx_event_t rx_event_i,
  output uart_pkg::divisor_t  divisor_o,
  output logic                div_load_o
);

  ////////////////////////////////////////
  // Response phase state
  ////////////////////////////////////////

  logic                req_q;              // Doubles as rvalid
  logic                we_q;
  logic                w_err_d, w_err_q;   // Write decode result
  uart_pkg::reg_addr_t addr_d, addr_q;

  // Programmer visible registers
  uart_pkg::byte_t    ier_d, ier_q;
  uart_pkg::byte_t    lcr_d, lcr_q;
  uart_pkg::divisor_t div_d, div_q;
  uart_pkg::byte_t    rhr_q;               // Last received char
  logic               dr_d, dr_q;
  logic               oe_d, oe_q;          // Sticky until RHR read
  logic               fe_d, fe_q;

  logic            dlab;
  logic            wr_req;                 // Write in request cycle
  logic            rd_rsp;                 // Read in response cycle
  logic            rd_rhr;                 // RHR being read out
  logic            rd_err;
  uart_pkg::byte_t rd_data;
  uart_pkg::byte_t lsr;

  assign addr_d    = bus_req_i.addr[uart_pkg::AddrOffset +: uart_pkg::AddrBits];
  assign dlab      = lcr_q[uart_pkg::LCR_DLAB];
  assign wr_req    = bus_req_i.req & bus_req_i.we;
  assign rd_rsp    = req_q & ~we_q;
  assign divisor_o = div_q;

  // Line status view
  always_comb begin
    lsr                     = '0;
    lsr[uart_pkg::LSR_DR]   = dr_q;
    lsr[uart_pkg::LSR_OE]   = oe_q;
    lsr[uart_pkg::LSR_FE]   = fe_q;
    lsr[uart_pkg::LSR_THRE] = ~tx_busy_i;  // No holding reg, tracks shifter
    lsr[uart_pkg::LSR_TEMT] = ~tx_busy_i;
  end

  ////////////////////////////////////////
  // Write decode, request cycle
  ////////////////////////////////////////

  always_comb begin
    ier_d          = ier_q;
    lcr_d          = lcr_q;
    div_d          = div_q;
    w_err_d        = 1'b0;
    div_load_o     = 1'b0;
    tx_cmd_o.start = 1'b0;
    tx_cmd_o.data  = bus_req_i.wdata[uart_pkg::RegWidth-1:0];

    if (wr_req) begin
      if (!dlab) begin
        case (addr_d)
          uart_pkg::RHR_THR_DLL: tx_cmd_o.start = ~tx_busy_i;  // Lost if busy
          uart_pkg::IER_DLM:     ier_d = bus_req_i.wdata[uart_pkg::RegWidth-1:0];
          uart_pkg::LCR:         lcr_d = bus_req_i.wdata[uart_pkg::RegWidth-1:0];
          uart_pkg::LSR:         ;  // Read only, write ignored
          uart_pkg::SPR:         ;  // Accepted, nothing stored
          default:               w_err_d = 1'b1;
        endcase
      end else begin
        case (addr_d)
          uart_pkg::RHR_THR_DLL: begin
            div_d[uart_pkg::RegWidth-1:0] = bus_req_i.wdata[uart_pkg::RegWidth-1:0];
            div_load_o = 1'b1;
          end
          uart_pkg::IER_DLM: begin
            div_d[2*uart_pkg::RegWidth-1:uart_pkg::RegWidth] =
              bus_req_i.wdata[uart_pkg::RegWidth-1:0];
            div_load_o = 1'b1;
          end
          uart_pkg::LCR: lcr_d = bus_req_i.wdata[uart_pkg::RegWidth-1:0];
          uart_pkg::SPR: ;
          default:       w_err_d = 1'b1;  // LSR hidden too
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Read decode, response cycle
  ////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    rd_rhr  = 1'b0;

    if (rd_rsp) begin
      if (!dlab) begin
        case (addr_q)
          uart_pkg::RHR_THR_DLL: begin
            rd_data = rhr_q;
            rd_rhr  = 1'b1;
          end
          uart_pkg::IER_DLM: rd_data = ier_q;
          uart_pkg::LCR:     rd_data = lcr_q;
          uart_pkg::LSR:     rd_data = lsr;
          uart_pkg::SPR:     rd_data = '0;  // Scratch not kept
          default:           rd_err  = 1'b1;
        endcase
      end else begin
        case (addr_q)
          uart_pkg::RHR_THR_DLL: rd_data = div_q[uart_pkg::RegWidth-1:0];
          uart_pkg::IER_DLM:     rd_data = div_q[2*uart_pkg::RegWidth-1:uart_pkg::RegWidth];
          uart_pkg::LCR:         rd_data = lcr_q;
          uart_pkg::SPR:         rd_data = '0;
          default:               rd_err  = 1'b1;
        endcase
      end
    end
  end

  // Status update, receive event wins over read clear
  always_comb begin
    dr_d = dr_q;
    oe_d = oe_q;
    fe_d = fe_q;
    if (rd_rhr) begin
      dr_d = 1'b0;
      oe_d = 1'b0;
    end
    if (rx_event_i.valid) begin
      dr_d = 1'b1;
      fe_d = rx_event_i.frame_err;
      if (dr_q && !rd_rhr) oe_d = 1'b1;  // Unread char overwritten
    end
  end

  // Response mux
  always_comb begin
    bus_rsp_o        = '0;
    bus_rsp_o.gnt    = bus_req_i.req;  // Always ready
    bus_rsp_o.rvalid = req_q;
    bus_rsp_o.err    = w_err_q;
    if (rd_rsp) begin
      bus_rsp_o.rdata[uart_pkg::RegWidth-1:0] = rd_data;
      bus_rsp_o.err                           = rd_err;
    end
  end

  ////////////////////////////////////////
  // Flops
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q   <= 1'b0;
      we_q    <= 1'b0;
      addr_q  <= '0;
      w_err_q <= 1'b0;
      ier_q   <= '0;
      lcr_q   <= uart_pkg::REG_RESET_LCR;
      div_q   <= uart_pkg::REG_RESET_DIV;
      dr_q    <= 1'b0;
      oe_q    <= 1'b0;
      fe_q    <= 1'b0;
    end else begin
      req_q   <= bus_req_i.req;
      we_q    <= bus_req_i.we;
      addr_q  <= addr_d;
      w_err_q <= w_err_d;
      ier_q   <= ier_d;
      lcr_q   <= lcr_d;
      div_q   <= div_d;
      dr_q    <= dr_d;
      oe_q    <= oe_d;
      fe_q    <= fe_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_event_i.valid) rhr_q <= rx_event_i.data;
  end

endmodule

//--- hw/uart_baud_gen.sv
// Baud rate generator
// Down-counter that emits one 16x oversampling tick every divisor clocks

module uart_baud_gen (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  uart_pkg::divisor_t divisor_i,
  input  logic               div_load_i,
  output logic               tick_o
);

  uart_pkg::divisor_t cnt_d, cnt_q;
  logic               load_q;        // New divisor visible this cycle
  logic               tick_d, tick_q;

  always_comb begin
    cnt_d  = cnt_q;
    tick_d = 1'b0;
    if (divisor_i == '0) begin
      cnt_d = '0;                    // Stopped, no ticks
    end else if (load_q) begin
      cnt_d = uart_pkg::divisor_t'(divisor_i - 1'b1);  // Restart period
    end else if (cnt_q == '0) begin
      cnt_d  = uart_pkg::divisor_t'(divisor_i - 1'b1);
      tick_d = 1'b1;
    end else begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      load_q <= 1'b0;
      tick_q <= 1'b0;
    end else begin
      cnt_q  <= cnt_d;
      load_q <= div_load_i;          // Divisor lands with the write
      tick_q <= tick_d;
    end
  end

  assign tick_o = tick_q;

endmodule

//--- hw/uart_tx/uart_tx.sv
// UART transmitter
// Sends one 8N1 frame per start pulse, LSB first, each bit lasting
// OversampleRate ticks

module uart_tx (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              tick_i,
  input  uart_pkg::tx_cmd_t tx_cmd_i,
  output logic              busy_o,
  output logic              uart_tx_o
);

  localparam uart_pkg::tick_cnt_t LastTick = uart_pkg::tick_cnt_t'(uart_pkg::OversampleRate - 1);
  localparam uart_pkg::bit_cnt_t  LastBit  = uart_pkg::bit_cnt_t'(uart_pkg::RegWidth - 1);

  uart_pkg::tx_state_e state_q;
  uart_pkg::tick_cnt_t tick_cnt_q;
  uart_pkg::bit_cnt_t  bit_cnt_q;
  uart_pkg::byte_t     shift_q;      // Outgoing char, bit 0 on the line
  logic                bit_end;

  assign bit_end = tick_i && (tick_cnt_q == LastTick);

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= uart_pkg::TX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else begin
      if (state_q != uart_pkg::TX_IDLE && tick_i) tick_cnt_q <= tick_cnt_q + 1'b1;
      case (state_q)
        uart_pkg::TX_IDLE: begin
          tick_cnt_q <= '0;
          bit_cnt_q  <= '0;
          if (tx_cmd_i.start) state_q <= uart_pkg::TX_START;
        end
        uart_pkg::TX_START: if (bit_end) state_q <= uart_pkg::TX_DATA;
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == LastBit) state_q <= uart_pkg::TX_STOP;
          end
        end
        uart_pkg::TX_STOP: if (bit_end) state_q <= uart_pkg::TX_IDLE;  // Frame done
        default: state_q <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // Shifter
  always_ff @(posedge clk_i) begin
    if (state_q == uart_pkg::TX_IDLE && tx_cmd_i.start) begin
      shift_q <= tx_cmd_i.data;
    end else if (state_q == uart_pkg::TX_DATA && bit_end) begin
      shift_q <= shift_q >> 1;  // Next bit down
    end
  end

  // Line driver, idle high
  always_comb begin
    case (state_q)
      uart_pkg::TX_START: uart_tx_o = 1'b0;
      uart_pkg::TX_DATA:  uart_tx_o = shift_q[0];
      default:            uart_tx_o = 1'b1;  // Idle and stop bit
    endcase
  end

  assign busy_o = (state_q != uart_pkg::TX_IDLE);

endmodule

//--- hw/uart_rx/uart_rx.sv
// UART receiver
// Synchronizes the line, waits for a falling edge and samples each bit
// at mid-bit with 16x oversampling. Reports the byte and a low stop bit

module uart_rx (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                tick_i,
  input  logic                uart_rx_i,
  output uart_pkg::rx_event_t rx_event_o
);

  localparam uart_pkg::tick_cnt_t MidTick  =
    uart_pkg::tick_cnt_t'(uart_pkg::OversampleRate / 2 - 1);
  localparam uart_pkg::tick_cnt_t LastTick =
    uart_pkg::tick_cnt_t'(uart_pkg::OversampleRate - 1);
  localparam uart_pkg::bit_cnt_t  LastBit  = uart_pkg::bit_cnt_t'(uart_pkg::RegWidth - 1);

  ////////////////////////////////////////
  // Line synchronizer
  ////////////////////////////////////////

  logic [1:0] sync_q;     // Two flop sync
  logic       rx_s;       // Synchronized line
  logic       rx_prev_q;  // For edge detect
  logic       fall;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q    <= 2'b11;  // Idle line high
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], uart_rx_i};
      rx_prev_q <= rx_s;
    end
  end

  assign rx_s = sync_q[1];
  assign fall = rx_prev_q & ~rx_s;

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  uart_pkg::rx_state_e state_q;
  uart_pkg::tick_cnt_t tick_cnt_q;
  uart_pkg::bit_cnt_t  bit_cnt_q;
  uart_pkg::byte_t     shift_q;   // Assembled LSB first
  logic                valid_q;
  logic                fe_q;
  logic                sample;    // Mid-bit point of data or stop

  assign sample = tick_i && (tick_cnt_q == LastTick);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= uart_pkg::RX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      valid_q    <= 1'b0;
      fe_q       <= 1'b0;
    end else begin
      valid_q <= 1'b0;  // Single cycle event
      if (state_q != uart_pkg::RX_IDLE && tick_i) tick_cnt_q <= tick_cnt_q + 1'b1;
      case (state_q)
        uart_pkg::RX_IDLE: begin
          tick_cnt_q <= '0;
          bit_cnt_q  <= '0;
          if (fall) state_q <= uart_pkg::RX_START;
        end
        uart_pkg::RX_START: begin
          if (tick_i && tick_cnt_q == MidTick) begin
            tick_cnt_q <= '0;  // Realign to mid-bit
            state_q    <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;  // Glitch check
          end
        end
        uart_pkg::RX_DATA: begin
          if (sample) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == LastBit) state_q <= uart_pkg::RX_STOP;
          end
        end
        uart_pkg::RX_STOP: begin
          if (sample) begin
            valid_q <= 1'b1;
            fe_q    <= ~rx_s;  // Stop bit must be high
            state_q <= uart_pkg::RX_IDLE;
          end
        end
        default: state_q <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // Data shifter
  always_ff @(posedge clk_i) begin
    if (state_q == uart_pkg::RX_DATA && sample) shift_q <= {rx_s, shift_q[uart_pkg::RegWidth-1:1]};
  end

  assign rx_event_o.valid     = valid_q;
  assign rx_event_o.data      = shift_q;  // Stable until next frame
  assign rx_event_o.frame_err = fe_q;

endmodule

//--- hw/uart_top.sv
// UART top level
// Register block, baud generator, transmitter and receiver

module uart_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  uart_pkg::bus_req_t bus_req_i,
  output uart_pkg::bus_rsp_t bus_rsp_o,
  input  logic               uart_rx_i,
  output logic               uart_tx_o
);

  uart_pkg::tx_cmd_t   tx_cmd;    // THR write to shifter
  uart_pkg::rx_event_t rx_event;  // Received char
  uart_pkg::divisor_t  divisor;
  logic                div_load;
  logic                tx_busy;
  logic                tick;      // 16x bit rate

  uart_regs i_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bus_req_i  (bus_req_i),
    .bus_rsp_o  (bus_rsp_o),
    .tx_cmd_o   (tx_cmd),
    .tx_busy_i  (tx_busy),
    .rx_event_i (rx_event),
    .divisor_o  (divisor),
    .div_load_o (div_load)
  );

  uart_baud_gen i_baud_gen (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .divisor_i  (divisor),
    .div_load_i (div_load),
    .tick_o     (tick)
  );

  uart_tx i_tx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .tick_i    (tick),
    .tx_cmd_i  (tx_cmd),
    .busy_o    (tx_busy),
    .uart_tx_o (uart_tx_o)
  );

  uart_rx i_rx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .tick_i     (tick),
    .uart_rx_i  (uart_rx_i),
    .rx_event_o (rx_event)
  );

endmodule

//--- sim/tb_uart.sv
// UART testbench
// Random register traffic and serial frames checked against a register
// and line model. Loopback covers the transmitter and a serial driver feeds the receiver

module tb_uart;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned ClkPeriod   = 10;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned MaxDiv      = 4;   // Loopback divisor range 1..4
  // Start, data, stop and one idle bit at the slowest divisor
  localparam int unsigned FrameCycles =
    (uart_pkg::RegWidth + 3) * uart_pkg::OversampleRate * MaxDiv;
  localparam int unsigned NumFrames   = 5;
  localparam int unsigned NumAccesses = 200;  // Bus accesses outside polling
  localparam int unsigned TimeoutNs   =
    2 * ClkPeriod * (ResetCycles + NumFrames * FrameCycles + 3 * NumAccesses);
  localparam int unsigned MaxPolls    = FrameCycles;

  logic               clk;
  logic               rst_n;
  uart_pkg::bus_req_t bus_req;
  uart_pkg::bus_rsp_t bus_rsp;
  logic               uart_tx;
  logic               uart_rx;
  logic               use_loop;   // Tx looped back to rx
  logic               line_drv;   // Serial driver output

  integer seed;
  int     checks, errors;
  int     test_num, chk0, err0;   // Counts at test start

  // Register and line model
  uart_pkg::byte_t    ier_m, lcr_m, rhr_m;
  uart_pkg::divisor_t div_m;
  logic               dr_m, oe_m, fe_m;

  assign uart_rx = use_loop ? uart_tx : line_drv;  // Line mux

  uart_top UUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .uart_rx_i (uart_rx),
    .uart_tx_o (uart_tx)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Model
  ////////////////////////////////////////

  // Unmapped slots under the current DLAB
  function automatic logic slot_err(input uart_pkg::reg_addr_t slot);
    case (slot)
      uart_pkg::RHR_THR_DLL, uart_pkg::IER_DLM: return 1'b0;
      uart_pkg::LCR, uart_pkg::SPR:             return 1'b0;
      uart_pkg::LSR:                            return lcr_m[uart_pkg::LCR_DLAB];
      default:                                  return 1'b1;
    endcase
  endfunction

  function automatic uart_pkg::byte_t lsr_model();
    uart_pkg::byte_t v;
    v                     = '0;
    v[uart_pkg::LSR_DR]   = dr_m;
    v[uart_pkg::LSR_OE]   = oe_m;
    v[uart_pkg::LSR_FE]   = fe_m;
    v[uart_pkg::LSR_THRE] = 1'b1;  // Transmitter idle whenever LSR is checked
    v[uart_pkg::LSR_TEMT] = 1'b1;
    return v;
  endfunction

  function automatic uart_pkg::byte_t model_rd_data(input uart_pkg::reg_addr_t slot);
    if (lcr_m[uart_pkg::LCR_DLAB]) begin
      case (slot)
        uart_pkg::RHR_THR_DLL: return div_m[7:0];
        uart_pkg::IER_DLM:     return div_m[15:8];
        uart_pkg::LCR:         return lcr_m;
        default:               return 8'h00;
      endcase
    end
    case (slot)
      uart_pkg::RHR_THR_DLL: return rhr_m;
      uart_pkg::IER_DLM:     return ier_m;
      uart_pkg::LCR:         return lcr_m;
      uart_pkg::LSR:         return lsr_model();
      default:               return 8'h00;  // SPR reads zero
    endcase
  endfunction

  task automatic model_write(input uart_pkg::reg_addr_t slot, input uart_pkg::byte_t data);
    if (lcr_m[uart_pkg::LCR_DLAB]) begin
      if (slot == uart_pkg::RHR_THR_DLL) div_m[7:0] = data;
      if (slot == uart_pkg::IER_DLM) div_m[15:8] = data;
    end else if (slot == uart_pkg::IER_DLM) begin
      ier_m = data;
    end
    if (slot == uart_pkg::LCR) lcr_m = data;
  endtask

  // Received char lands in RHR
  task automatic model_rx(input uart_pkg::byte_t data, input logic frame_err);
    if (dr_m) oe_m = 1'b1;  // Previous char never read
    rhr_m = data;
    fe_m  = frame_err;
    dr_m  = 1'b1;
  endtask

  ////////////////////////////////////////
  // Checks and bus tasks
  ////////////////////////////////////////

  task automatic check_val(input string what, input uart_pkg::reg_addr_t slot,
                           input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error at %0d ns: %s at slot %0d is %h, expected %h",
               $time, what, slot, got, exp);
      errors++;
    end
  endtask

  task automatic bus_access(input logic we, input uart_pkg::reg_addr_t slot,
                            input logic [31:0] wdata, output uart_pkg::bus_rsp_t rsp);
    @(negedge clk);
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = 32'(slot) << uart_pkg::AddrOffset;
    bus_req.wdata = wdata;
    #1;
    checks++;
    assert (bus_rsp.gnt && !bus_rsp.rvalid) else begin
      $display("Request to slot %0d was not granted alone in its own cycle", slot);
      errors++;
    end
    @(negedge clk);  // Response cycle
    rsp     = bus_rsp;
    bus_req = '0;
    checks++;
    assert (rsp.rvalid) else begin
      $display("No response one cycle after the request to slot %0d", slot);
      errors++;
    end
  endtask

  task automatic bus_write(input uart_pkg::reg_addr_t slot, input logic [31:0] wdata,
                           output uart_pkg::bus_rsp_t rsp);
    bus_access(1'b1, slot, wdata, rsp);
  endtask

  task automatic bus_read(input uart_pkg::reg_addr_t slot, output uart_pkg::bus_rsp_t rsp);
    bus_access(1'b0, slot, '0, rsp);
  endtask

  task automatic reg_write(input uart_pkg::reg_addr_t slot, input logic [31:0] wdata);
    uart_pkg::bus_rsp_t rsp;
    logic               exp_err;
    exp_err = slot_err(slot);  // DLAB at request time
    bus_write(slot, wdata, rsp);
    check_val("Write err", slot, rsp.err, exp_err);
    check_val("Write rdata", slot, rsp.rdata, '0);
    if (!exp_err) model_write(slot, wdata[7:0]);
  endtask

  task automatic reg_read(input uart_pkg::reg_addr_t slot);
    uart_pkg::bus_rsp_t rsp;
    logic               exp_err;
    uart_pkg::byte_t    exp_data;
    exp_err  = slot_err(slot);
    exp_data = model_rd_data(slot);
    bus_read(slot, rsp);
    check_val("Read err", slot, rsp.err, exp_err);
    if (!exp_err) check_val("Read data", slot, rsp.rdata, {24'b0, exp_data});
    // RHR read clears status
    if (!exp_err && !lcr_m[uart_pkg::LCR_DLAB] && slot == uart_pkg::RHR_THR_DLL) begin
      dr_m = 1'b0;
      oe_m = 1'b0;
    end
  endtask

  task automatic set_divisor(input uart_pkg::divisor_t div);
    reg_write(uart_pkg::LCR, {24'b0, 1'b1, lcr_m[6:0]});
    reg_write(uart_pkg::RHR_THR_DLL, {24'b0, div[7:0]});
    reg_write(uart_pkg::IER_DLM, {24'b0, div[15:8]});
    reg_write(uart_pkg::LCR, {24'b0, 1'b0, lcr_m[6:0]});
  endtask

  // Wait on an LSR bit by polling
  task automatic poll_lsr(input int bit_idx, input logic want);
    uart_pkg::bus_rsp_t rsp;
    int                 n;
    n = 0;
    bus_read(uart_pkg::LSR, rsp);
    while (rsp.rdata[bit_idx] !== want && n < MaxPolls) begin
      bus_read(uart_pkg::LSR, rsp);
      n++;
    end
    checks++;
    assert (rsp.rdata[bit_idx] === want) else begin
      $display("LSR bit %0d did not become %0b within %0d polls", bit_idx, want, MaxPolls);
      errors++;
    end
  endtask

  // One 8N1 frame plus an idle bit timed from the model divisor
  task automatic send_frame(input uart_pkg::byte_t data, input logic stop);
    logic [10:0] bits;
    int unsigned bit_cycles;
    bits       = {1'b1, stop, data, 1'b0};  // Start bit first
    bit_cycles = uart_pkg::OversampleRate * div_m;
    for (int i = 0; i < 11; i++) begin
      @(negedge clk);
      line_drv = bits[i];
      repeat (bit_cycles - 1) @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name);
    $display("Test %0d %s: %0d checks, %0d errors",
             test_num, name, checks - chk0, errors - err0);
    test_num++;
    chk0 = checks;
    err0 = errors;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin : stimulus
    logic [31:0]     r;
    uart_pkg::byte_t b1, b2;
    seed     = 32'h8750_7111;
    checks   = 0;
    errors   = 0;
    test_num = 1;
    chk0     = 0;
    err0     = 0;
    rst_n    = 1'b0;
    bus_req  = '0;
    use_loop = 1'b1;
    line_drv = 1'b1;  // Idle line
    ier_m    = 8'h00;
    lcr_m    = 8'h00;
    rhr_m    = 8'h00;
    div_m    = 16'h0001;
    dr_m     = 1'b0;
    oe_m     = 1'b0;
    fe_m     = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;

    reg_read(uart_pkg::LCR);
    reg_read(uart_pkg::LSR);  // 8'h60
    reg_write(uart_pkg::LCR, 32'h80);
    reg_read(uart_pkg::RHR_THR_DLL);
    reg_read(uart_pkg::IER_DLM);
    reg_write(uart_pkg::LCR, 32'h00);
    finish_test("reset values");

    repeat (12) begin
      r = $random(seed);
      case (r[9:8])
        2'd0: reg_write(uart_pkg::IER_DLM, r);
        2'd1: reg_write(uart_pkg::LCR, r & 32'hffff_ff7f);  // DLAB stays 0
        default: reg_write(uart_pkg::SPR, r);
      endcase
      reg_read(uart_pkg::IER_DLM);
      reg_read(uart_pkg::LCR);
      reg_read(uart_pkg::SPR);
    end
    finish_test("register access");

    for (int k = 2; k <= 6; k += 2) begin
      reg_write(uart_pkg::reg_addr_t'(k), $random(seed));
      reg_read(uart_pkg::reg_addr_t'(k));
    end
    r = $random(seed);
    reg_write(uart_pkg::LCR, r | 32'h80);
    reg_write(uart_pkg::RHR_THR_DLL, $random(seed));
    reg_write(uart_pkg::IER_DLM, $random(seed));  // Goes to DLM and leaves IER alone
    reg_read(uart_pkg::RHR_THR_DLL);
    reg_read(uart_pkg::IER_DLM);
    reg_read(uart_pkg::LSR);
    reg_write(uart_pkg::LSR, $random(seed));
    for (int k = 2; k <= 6; k += 2) reg_read(uart_pkg::reg_addr_t'(k));
    reg_read(uart_pkg::LCR);
    reg_write(uart_pkg::LCR, {24'b0, 1'b0, lcr_m[6:0]});
    reg_read(uart_pkg::IER_DLM);
    finish_test("address decode");

    r = $random(seed);
    set_divisor(16'(r[1:0]) + 16'd1);
    use_loop = 1'b1;
    b1       = 8'($random(seed));
    reg_write(uart_pkg::RHR_THR_DLL, {24'b0, b1});
    poll_lsr(uart_pkg::LSR_THRE, 1'b0);
    poll_lsr(uart_pkg::LSR_TEMT, 1'b0);  // Shifter still busy
    poll_lsr(uart_pkg::LSR_THRE, 1'b1);  // Frame sent
    poll_lsr(uart_pkg::LSR_DR, 1'b1);
    model_rx(b1, 1'b0);
    reg_read(uart_pkg::LSR);
    reg_read(uart_pkg::RHR_THR_DLL);
    reg_read(uart_pkg::LSR);
    finish_test("loopback");

    use_loop = 1'b0;
    b1       = 8'($random(seed));
    b2       = 8'($random(seed));
    send_frame(b1, 1'b1);
    model_rx(b1, 1'b0);
    send_frame(b2, 1'b1);
    model_rx(b2, 1'b0);
    reg_read(uart_pkg::LSR);  // DR and OE
    reg_read(uart_pkg::RHR_THR_DLL);
    reg_read(uart_pkg::LSR);
    finish_test("overrun");

    b1 = 8'($random(seed));
    b2 = 8'($random(seed));
    send_frame(b1, 1'b0);    // Low stop bit
    model_rx(b1, 1'b1);
    reg_read(uart_pkg::LSR);
    reg_read(uart_pkg::RHR_THR_DLL);
    reg_read(uart_pkg::LSR);  // FE still set
    send_frame(b2, 1'b1);
    model_rx(b2, 1'b0);
    reg_read(uart_pkg::LSR);
    reg_read(uart_pkg::RHR_THR_DLL);
    reg_read(uart_pkg::LSR);
    finish_test("framing error");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_num - 1, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Bound from frame count and bus traffic
  initial begin : watchdog
    #(TimeoutNs);
    $display("Simulation hung, no finish within %0d ns", TimeoutNs);
    $display("Errors found");
    $finish;
  end

endmodule

//--- all.f
common/uart_pkg.sv
hw/uart_regs/uart_regs.sv
hw/uart_baud_gen.sv
hw/uart_tx/uart_tx.sv
hw/uart_rx/uart_rx.sv
hw/uart_top.sv
sim/tb_uart.sv

//--- Bender.yml
package:
  name: uart_lite

sources:
  - common/uart_pkg.sv
  - hw/uart_regs/uart_regs.sv
  - hw/uart_baud_gen.sv
  - hw/uart_tx/uart_tx.sv
  - hw/uart_rx/uart_rx.sv
  - hw/uart_top.sv
  - target: simulation
    files:
      - sim/tb_uart.sv
